//--- Bender.yml
package:
  name: l2c_top

sources:
  - verilog/l2c_pkg.sv
  - verilog/layer_cfg_if.sv
  - verilog/l2c_cfg_regs.sv
  - verilog/l2c_normal_loop.sv
  - verilog/fifo_done_tracker.sv
  - verilog/l2c_top.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/l2c_top_sva.sv
      - tests/tb_l2c_top.sv

//--- l2c_top.f
verilog/l2c_pkg.sv
verilog/layer_cfg_if.sv
verilog/l2c_cfg_regs.sv
verilog/l2c_normal_loop.sv
verilog/fifo_done_tracker.sv
verilog/l2c_top.sv
tests/tb_clk_gen.sv
tests/l2c_top_sva.sv
tests/tb_l2c_top.sv

//--- tests/l2c_top_sva.sv
//====================================================================
// l2c_top protocol assertions
// need masks, done pulse and tracker reload rules
//====================================================================
`timescale 1ns/1ps

module l2c_top_sva (
    input logic                          clk,
    input logic                          rst_n,
    input logic [l2c_pkg::NUM_FIFO-1:0]  ifmap_need_i,
    input logic [l2c_pkg::NUM_FIFO-1:0]  ipsum_need_i,
    input logic [l2c_pkg::NUM_FIFO-1:0]  opsum_need_i,
    input logic [l2c_pkg::NUM_FIFO-1:0]  ifmap_done_i,
    input logic [l2c_pkg::NUM_FIFO-1:0]  ipsum_done_i,
    input logic [l2c_pkg::NUM_FIFO-1:0]  opsum_done_i,
    input logic                          loop_done_i
);

    int unsigned fail_cnt = 0;                 // failed assertions so far
    logic        any_need;
    logic        all_done;

    assign any_need = |{ifmap_need_i, ipsum_need_i, opsum_need_i};
    assign all_done = &{ifmap_done_i, ipsum_done_i, opsum_done_i};

    need_one_cycle_a: assert property (@(posedge clk) disable iff (!rst_n)
        any_need |=> !any_need)
        else begin
            fail_cnt++;
            $error("need mask stayed nonzero for more than one cycle");
        end

    done_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
        loop_done_i |=> !loop_done_i)
        else begin
            fail_cnt++;
            $error("loop_done_o lasted longer than one cycle");
        end

    done_after_drain_a: assert property (@(posedge clk) disable iff (!rst_n)
        loop_done_i |-> $past(all_done))
        else begin
            fail_cnt++;
            $error("loop_done_o without all done bits high the cycle before");
        end

    // a tracker must be idle before it is reloaded
    reload_idle_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(|(ifmap_need_i & ~$past(ifmap_done_i)) ||
          |(ipsum_need_i & ~$past(ipsum_done_i)) ||
          |(opsum_need_i & ~$past(opsum_done_i))))
        else begin
            fail_cnt++;
            $error("need bit raised for a fifo that was still counting");
        end

endmodule

bind l2c_top l2c_top_sva sva_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .ifmap_need_i (ifmap_need_o),
    .ipsum_need_i (ipsum_need_o),
    .opsum_need_i (opsum_need_o),
    .ifmap_done_i (ifmap_done_o),
    .ipsum_done_i (ipsum_done_o),
    .opsum_done_i (opsum_done_o),
    .loop_done_i  (loop_done_o)
);

//--- tests/tb_clk_gen.sv
//====================================================================
// testbench clock and reset
// 100 ns clock, reset held low for the first 10 cycles
//====================================================================
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;            // half of 100 ns
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (10) @(posedge clk_o);
        #1 rst_n_o = 1'b1;                     // release off the edge
    end

endmodule

//--- tests/tb_l2c_top.sv
//====================================================================
// l2c_top testbench
// configures each layer type, drains the trackers in lfsr order and
// checks masks, done bits and the loop done pulse
//====================================================================
`timescale 1ns/1ps

module tb_l2c_top;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic        cfg_we;
    logic        cfg_addr;
    logic [31:0] cfg_wdata;
    logic [31:0] ifmap_pop;
    logic [31:0] ipsum_pop;
    logic [31:0] opsum_push;
    logic [31:0] ifmap_need;
    logic [31:0] ipsum_need;
    logic [31:0] opsum_need;
    logic [31:0] ifmap_done;
    logic [31:0] ipsum_done;
    logic [31:0] opsum_done;
    logic        loop_done;

    int          rem_if [32];                  // pops still owed per fifo
    int          rem_ips [32];
    int          rem_ops [32];                 // pushes still owed
    logic [31:0] exp_if_mask;
    logic [31:0] exp_ps_mask;                  // ipsum and opsum share it
    logic [31:0] lfsr_q = 32'hb977_3efc;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          test_err0 = 0;
    int unsigned cycle_cnt = 0;
    int unsigned cycle_limit = 4000;           // 7 loops of about 40 cycles plus margin

    tb_clk_gen clk_gen_inst (.clk_o(clk), .rst_n_o(rst_n));

    l2c_top l2c_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start),
        .cfg_we_i     (cfg_we),
        .cfg_addr_i   (cfg_addr),
        .cfg_wdata_i  (cfg_wdata),
        .ifmap_pop_i  (ifmap_pop),
        .ipsum_pop_i  (ipsum_pop),
        .opsum_push_i (opsum_push),
        .ifmap_need_o (ifmap_need),
        .ipsum_need_o (ipsum_need),
        .opsum_need_o (opsum_need),
        .ifmap_done_o (ifmap_done),
        .ipsum_done_o (ipsum_done),
        .opsum_done_o (opsum_done),
        .loop_done_o  (loop_done)
    );

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: run exceeded %0d cycles", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    //================================================================
    // helpers
    //================================================================
    function automatic logic [31:0] low_bits(input int k);
        if (k >= 32) begin
            return 32'hffff_ffff;              // capped at bank size
        end
        return (32'h1 << k) - 32'h1;
    endfunction

    // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic rand_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        return b;
    endfunction

    function automatic logic [31:0] done_of(input int rem [32]);
        logic [31:0] d;
        for (int f = 0; f < 32; f++) begin
            d[f] = (rem[f] == 0);
        end
        return d;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;                                    // drive and sample off the edge
    endtask

    task automatic check_value(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        assert (act === exp) else begin
            $display("CHECK FAILED %s expected 0x%08h actual 0x%08h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_done_bits();
        check_value("ifmap_done_o", ifmap_done, done_of(rem_if));
        check_value("ipsum_done_o", ipsum_done, done_of(rem_ips));
        check_value("opsum_done_o", opsum_done, done_of(rem_ops));
    endtask

    task automatic write_cfg(input logic addr, input logic [31:0] data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        tick();
        cfg_we    = 1'b0;
    endtask

    //================================================================
    // expected masks and counts per layer type
    //================================================================
    task automatic set_expect(input logic [1:0] lt, input int ic, input int oc,
                              input l2c_pkg::l2c_geom_u g);
        int w;
        int ifc;
        int ips;
        int ops;
        w = g.conv.in_c + g.conv.pad_r + g.conv.pad_l;
        exp_if_mask = (lt == l2c_pkg::LT_DEPTHWISE || lt == l2c_pkg::LT_STANDARD) ?
                      low_bits(3 * ic) : low_bits(ic);
        exp_ps_mask = low_bits(oc);
        for (int f = 0; f < 32; f++) begin
            case (lt)
                l2c_pkg::LT_POINTWISE: begin
                    ifc = g.vec.tile_n;
                    ips = (f == 0) ? g.vec.on_real : g.vec.on_real + 1;
                    ops = g.vec.on_real;
                end
                l2c_pkg::LT_DEPTHWISE: begin
                    ifc = w - 3 * (f / 3 + 1) + 1;      // window slides per 3 fifos
                    ips = (f == 0) ? g.conv.out_c : g.conv.out_c + 1;
                    ops = g.conv.out_c;
                end
                l2c_pkg::LT_STANDARD: begin
                    ifc = w - 3;
                    ips = (f == 0) ? g.conv.out_c - 1 : g.conv.out_c;
                    ops = g.conv.out_c;
                end
                default: begin                          // linear
                    ifc = g.vec.tile_n - 1;
                    ips = (f == 0) ? g.vec.on_real - 1 : g.vec.on_real + 1;
                    ops = g.vec.on_real;
                end
            endcase
            rem_if[f]  = exp_if_mask[f] ? (ifc & 16'hffff) : 0;
            rem_ips[f] = exp_ps_mask[f] ? (ips & 16'hffff) : 0;
            rem_ops[f] = exp_ps_mask[f] ? (ops & 16'hffff) : 0;
        end
    endtask

    task automatic start_loop();
        start = 1'b1;
        tick();
        start = 1'b0;
        check_value("ifmap_need_o", ifmap_need, exp_if_mask);  // SET_NUM cycle
        check_value("ipsum_need_o", ipsum_need, exp_ps_mask);
        check_value("opsum_need_o", opsum_need, exp_ps_mask);
        tick();
        check_done_bits();                                     // counts loaded
    endtask

    // noise adds strobes on idle fifos, a restart and a config write
    task automatic drain_loop(input bit noise);
        logic [31:0] p_if;
        logic [31:0] p_ips;
        logic [31:0] p_ops;
        bit          first;
        first = 1'b1;
        while ((done_of(rem_if) & done_of(rem_ips) & done_of(rem_ops)) != 32'hffff_ffff) begin
            for (int f = 0; f < 32; f++) begin
                p_if[f]  = (rem_if[f] > 0) ? rand_bit() : noise;
                p_ips[f] = (rem_ips[f] > 0) ? rand_bit() : noise;
                p_ops[f] = (rem_ops[f] > 0) ? rand_bit() : noise;
            end
            ifmap_pop  = p_if;
            ipsum_pop  = p_ips;
            opsum_push = p_ops;
            if (noise && first) begin
                start = 1'b1;
                cfg_we = 1'b1;
                cfg_addr = l2c_pkg::CFG_ADDR_LAYER;
                cfg_wdata = 32'h0009_0903;     // linear layer with 9 in and 9 out
            end
            tick();
            start  = 1'b0;
            cfg_we = 1'b0;
            first  = 1'b0;
            for (int f = 0; f < 32; f++) begin
                if (p_if[f] && rem_if[f] > 0) rem_if[f]--;
                if (p_ips[f] && rem_ips[f] > 0) rem_ips[f]--;
                if (p_ops[f] && rem_ops[f] > 0) rem_ops[f]--;
            end
            check_done_bits();
            check_value("loop_done_o", loop_done, 32'h0);
        end
        ifmap_pop  = '0;
        ipsum_pop  = '0;
        opsum_push = '0;
        tick();
        check_value("loop_done_o", loop_done, 32'h1);  // one cycle after last event
        tick();
        check_value("loop_done_o", loop_done, 32'h0);
        check_value("ifmap_need_o", ifmap_need, 32'h0);
    endtask

    task automatic run_layer(input logic [1:0] lt, input logic [7:0] ic,
                             input logic [7:0] oc, input l2c_pkg::l2c_geom_u g,
                             input bit noise);
        write_cfg(l2c_pkg::CFG_ADDR_LAYER, {8'h00, oc, ic, 6'b0, lt});
        write_cfg(l2c_pkg::CFG_ADDR_GEOM, g);
        set_expect(lt, ic, oc, g);
        start_loop();
        drain_loop(noise);
    endtask

    function automatic l2c_pkg::l2c_geom_u conv_geom(input int in_c, input int pr,
                                                     input int pl, input int out_c);
        l2c_pkg::l2c_geom_u g;
        g = '0;
        g.conv.in_c  = in_c;
        g.conv.pad_r = pr;
        g.conv.pad_l = pl;
        g.conv.out_c = out_c;
        return g;
    endfunction

    function automatic l2c_pkg::l2c_geom_u vec_geom(input int tile_n, input int on_real);
        l2c_pkg::l2c_geom_u g;
        g = '0;
        g.vec.tile_n  = tile_n;
        g.vec.on_real = on_real;
        return g;
    endfunction

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_err0) begin
            tests_failed++;
            $display("test %-12s failed with %0d errors", name, errors - test_err0);
        end else begin
            $display("test %-12s ok", name);
        end
        test_err0 = errors;
    endtask

    //================================================================
    // test sequence
    //================================================================
    initial begin
        start      = 1'b0;
        cfg_we     = 1'b0;
        cfg_addr   = 1'b0;
        cfg_wdata  = '0;
        ifmap_pop  = '0;
        ipsum_pop  = '0;
        opsum_push = '0;
        @(posedge rst_n);
        tick();

        check_value("ifmap_need_o", ifmap_need, 32'h0);
        check_value("ipsum_need_o", ipsum_need, 32'h0);
        check_value("opsum_need_o", opsum_need, 32'h0);
        check_value("loop_done_o", loop_done, 32'h0);
        check_value("ifmap_done_o", ifmap_done, 32'hffff_ffff);
        check_value("ipsum_done_o", ipsum_done, 32'hffff_ffff);
        check_value("opsum_done_o", opsum_done, 32'hffff_ffff);
        write_cfg(l2c_pkg::CFG_ADDR_LAYER, 32'h0003_0500);     // geometry still missing
        start = 1'b1;
        tick();
        start = 1'b0;
        check_value("ifmap_need_o", ifmap_need, 32'h0);
        tick();
        check_value("ifmap_need_o", ifmap_need, 32'h0);
        end_test("reset");

        run_layer(l2c_pkg::LT_POINTWISE, 8'd5, 8'd3, vec_geom(4, 2), 1'b0);
        end_test("pointwise");

        run_layer(l2c_pkg::LT_DEPTHWISE, 8'd2, 8'd2, conv_geom(8, 1, 1, 4), 1'b0);
        end_test("depthwise");

        run_layer(l2c_pkg::LT_STANDARD, 8'd11, 8'd4, conv_geom(20, 0, 0, 3), 1'b0);
        run_layer(l2c_pkg::LT_LINEAR, 8'd6, 8'd3, vec_geom(3, 3), 1'b0);
        run_layer(l2c_pkg::LT_LINEAR, 8'd6, 8'd0, vec_geom(3, 3), 1'b0);
        end_test("std_linear");

        run_layer(l2c_pkg::LT_POINTWISE, 8'd5, 8'd3, vec_geom(4, 2), 1'b1);
        set_expect(l2c_pkg::LT_POINTWISE, 5, 3, vec_geom(4, 2));   // write was dropped
        start_loop();
        drain_loop(1'b0);
        end_test("ignored_ops");

        errors += l2c_top_inst.sva_inst.fail_cnt;
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- verilog/fifo_done_tracker.sv
//====================================================================
// fifo done tracker
// one down-counter per fifo, loaded on need, counted down by strobes
//====================================================================
`timescale 1ns/1ps

module fifo_done_tracker (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [l2c_pkg::NUM_FIFO-1:0]  need_i,        // load enables
    input  logic [l2c_pkg::CNT_W-1:0]     cnt_i [l2c_pkg::NUM_FIFO],
    input  logic [l2c_pkg::NUM_FIFO-1:0]  event_i,       // pop / push strobes
    output logic [l2c_pkg::NUM_FIFO-1:0]  done_o         // counter at zero
);

    logic [l2c_pkg::CNT_W-1:0] cnt_q [l2c_pkg::NUM_FIFO];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int f = 0; f < l2c_pkg::NUM_FIFO; f++) begin
                cnt_q[f] <= '0;
            end
        end else begin
            for (int f = 0; f < l2c_pkg::NUM_FIFO; f++) begin
                if (need_i[f]) begin
                    cnt_q[f] <= cnt_i[f];            // load wins over strobe
                end else if (event_i[f] && (cnt_q[f] != '0)) begin
                    cnt_q[f] <= cnt_q[f] - 1'b1;     // extra strobes dropped
                end
            end
        end
    end

    always_comb begin
        for (int f = 0; f < l2c_pkg::NUM_FIFO; f++) begin
            done_o[f] = (cnt_q[f] == '0);
        end
    end

endmodule

//--- verilog/l2c_cfg_regs.sv
//====================================================================
// l2c configuration registers
// latches layer word and geometry word, flags when both are present
//====================================================================
`timescale 1ns/1ps

module l2c_cfg_regs (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cfg_we_i,              // write strobe
    input  logic        cfg_addr_i,            // register select
    input  logic [31:0] cfg_wdata_i,           // write data
    layer_cfg_if.regs   cfg                    // to normal loop
);

    logic layer_seen_q;                        // layer word written
    logic geom_seen_q;                         // geometry word written
    logic wr_ok;
    logic wr_layer;
    logic wr_geom;

    // drop writes while a loop is in flight
    assign wr_ok    = cfg_we_i & ~cfg.busy;
    assign wr_layer = wr_ok & (cfg_addr_i == l2c_pkg::CFG_ADDR_LAYER);
    assign wr_geom  = wr_ok & (cfg_addr_i == l2c_pkg::CFG_ADDR_GEOM);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            layer_seen_q <= 1'b0;
            geom_seen_q  <= 1'b0;
        end else begin
            if (wr_layer) begin
                layer_seen_q <= 1'b1;              // sticky until reset
            end
            if (wr_geom) begin
                geom_seen_q <= 1'b1;
            end
        end
    end

    //================================================================
    // layer word holds type in [1:0], ic_real in [15:8], oc_real in [23:16]
    //================================================================
    always_ff @(posedge clk) begin
        if (wr_layer) begin
            cfg.layer_type <= cfg_wdata_i[1:0];
            cfg.ic_real    <= cfg_wdata_i[15:8];
            cfg.oc_real    <= cfg_wdata_i[23:16];
        end
        if (wr_geom) begin
            cfg.geom <= cfg_wdata_i;               // decoded later by type
        end
    end

    assign cfg.cfg_valid = layer_seen_q & geom_seen_q;

endmodule

//--- verilog/l2c_normal_loop.sv
//====================================================================
// l2c normal loop
// on start, emits fifo participation masks and per-fifo counts for
// one cycle, then waits for all trackers to drain before done
//====================================================================
`timescale 1ns/1ps

module l2c_normal_loop (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start_i,     // one-cycle strobe
    layer_cfg_if.loop                     cfg,
    output logic [l2c_pkg::NUM_FIFO-1:0]  ifmap_need_o,
    output logic [l2c_pkg::NUM_FIFO-1:0]  ipsum_need_o,
    output logic [l2c_pkg::NUM_FIFO-1:0]  opsum_need_o,
    output logic [l2c_pkg::CNT_W-1:0]     ifmap_cnt_o [l2c_pkg::NUM_FIFO],
    output logic [l2c_pkg::CNT_W-1:0]     ipsum_cnt_o [l2c_pkg::NUM_FIFO],
    output logic [l2c_pkg::CNT_W-1:0]     opsum_cnt_o [l2c_pkg::NUM_FIFO],
    input  logic [l2c_pkg::NUM_FIFO-1:0]  ifmap_done_i,
    input  logic [l2c_pkg::NUM_FIFO-1:0]  ipsum_done_i,
    input  logic [l2c_pkg::NUM_FIFO-1:0]  opsum_done_i,
    output logic                          loop_done_o  // one-cycle pulse
);

    enum logic [1:0] {IDLE, SET_NUM, WAIT_DONE, DONE} state_q, state_d;

    logic                          all_done;
    logic                          set_num;
    logic                          dw_mode;      // per-fifo ifmap offsets
    logic [9:0]                    ic_x3;        // 3 * ic_real
    logic [9:0]                    ifmap_k;      // ifmap fifos in use
    logic [l2c_pkg::NUM_FIFO-1:0]  oc_mask;
    logic [l2c_pkg::CNT_W-1:0]     in_c_w;
    logic [l2c_pkg::CNT_W-1:0]     out_c_w;
    logic [l2c_pkg::CNT_W-1:0]     w_pad;        // padded row length
    logic [l2c_pkg::CNT_W-1:0]     if_cnt;
    logic [l2c_pkg::CNT_W-1:0]     ips_first;    // ipsum fifo 0
    logic [l2c_pkg::CNT_W-1:0]     ips_rest;     // ipsum fifos 1 up
    logic [l2c_pkg::CNT_W-1:0]     ops_cnt;

    // lowest k bits set and all ones once k passes the bank size
    function automatic logic [l2c_pkg::NUM_FIFO-1:0] low_mask(input logic [9:0] k);
        return ~({l2c_pkg::NUM_FIFO{1'b1}} << k);
    endfunction

    //================================================================
    // state machine
    //================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign all_done = (&ifmap_done_i) & (&ipsum_done_i) & (&opsum_done_i);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:      if (start_i && cfg.cfg_valid) state_d = SET_NUM;
            SET_NUM:   state_d = WAIT_DONE;          // trackers load here
            WAIT_DONE: if (all_done) state_d = DONE;
            DONE:      state_d = IDLE;
            default:   state_d = IDLE;
        endcase
    end

    assign set_num     = (state_q == SET_NUM);
    assign cfg.busy    = (state_q != IDLE);        // freezes config regs
    assign loop_done_o = (state_q == DONE);

    //================================================================
    // geometry decode
    //================================================================
    assign in_c_w  = {{(l2c_pkg::CNT_W-8){1'b0}}, cfg.geom.conv.in_c};
    assign out_c_w = {{(l2c_pkg::CNT_W-8){1'b0}}, cfg.geom.conv.out_c};
    assign w_pad   = in_c_w + {{(l2c_pkg::CNT_W-2){1'b0}}, cfg.geom.conv.pad_r}
                            + {{(l2c_pkg::CNT_W-2){1'b0}}, cfg.geom.conv.pad_l};
    assign ic_x3   = {2'b00, cfg.ic_real} + {1'b0, cfg.ic_real, 1'b0};
    assign oc_mask = low_mask({2'b00, cfg.oc_real});

    always_comb begin
        dw_mode   = 1'b0;
        ifmap_k   = {2'b00, cfg.ic_real};
        if_cnt    = cfg.geom.vec.tile_n;
        ips_first = cfg.geom.vec.on_real;
        ips_rest  = cfg.geom.vec.on_real + 1'b1;
        ops_cnt   = cfg.geom.vec.on_real;
        case (cfg.layer_type)
            l2c_pkg::LT_DEPTHWISE: begin
                dw_mode   = 1'b1;
                ifmap_k   = ic_x3;                 // 3 rows per channel
                if_cnt    = w_pad + 1'b1;          // offset taken per fifo
                ips_first = out_c_w;
                ips_rest  = out_c_w + 1'b1;
                ops_cnt   = out_c_w;
            end
            l2c_pkg::LT_STANDARD: begin
                ifmap_k   = ic_x3;
                if_cnt    = w_pad - 2'd3;
                ips_first = out_c_w - 1'b1;
                ips_rest  = out_c_w;
                ops_cnt   = out_c_w;
            end
            l2c_pkg::LT_LINEAR: begin
                if_cnt    = cfg.geom.vec.tile_n - 1'b1;
                ips_first = cfg.geom.vec.on_real - 1'b1;
            end
            default: begin                         // pointwise keeps the defaults
            end
        endcase
    end

    //================================================================
    // masks and counts are live only during SET_NUM
    //================================================================
    always_comb begin
        int unsigned off;
        off          = 0;
        ifmap_need_o = '0;
        ipsum_need_o = '0;
        opsum_need_o = '0;
        for (int f = 0; f < l2c_pkg::NUM_FIFO; f++) begin
            ifmap_cnt_o[f] = '0;
            ipsum_cnt_o[f] = '0;
            opsum_cnt_o[f] = '0;
        end
        if (set_num) begin
            ifmap_need_o = low_mask(ifmap_k);
            ipsum_need_o = oc_mask;
            opsum_need_o = oc_mask;
            for (int f = 0; f < l2c_pkg::NUM_FIFO; f++) begin
                off = dw_mode ? 3 * (f / 3 + 1) : 0;   // window step per group
                ifmap_cnt_o[f] = if_cnt - off[l2c_pkg::CNT_W-1:0];
                ipsum_cnt_o[f] = (f == 0) ? ips_first : ips_rest;
                opsum_cnt_o[f] = ops_cnt;
            end
        end
    end

endmodule

//--- verilog/l2c_pkg.sv
//====================================================================
// l2c shared definitions
// layer-type codes, register map, bank sizing and the geometry word
//====================================================================
package l2c_pkg;

    localparam int NUM_FIFO = 32;              // fifos per bank
    localparam int CNT_W    = 16;              // pop / push count width

    // layer types
    localparam logic [1:0] LT_POINTWISE = 2'd0;
    localparam logic [1:0] LT_DEPTHWISE = 2'd1;
    localparam logic [1:0] LT_STANDARD  = 2'd2;
    localparam logic [1:0] LT_LINEAR    = 2'd3;

    // config register map
    localparam logic CFG_ADDR_LAYER = 1'b0;    // type + channel counts
    localparam logic CFG_ADDR_GEOM  = 1'b1;    // geometry word

    //================================================================
    // geometry word decoded by layer type
    //================================================================
    typedef union packed {
        struct packed {
            logic [11:0] rsvd;                 // unused
            logic [7:0]  out_c;                // output row length
            logic [1:0]  pad_l;                // left padding
            logic [1:0]  pad_r;                // right padding
            logic [7:0]  in_c;                 // input row length
        } conv;                                // depthwise / standard
        struct packed {
            logic [15:0] on_real;              // real output count
            logic [15:0] tile_n;               // tiles per row
        } vec;                                 // pointwise / linear
    } l2c_geom_u;

endpackage

//--- verilog/l2c_top.sv
//====================================================================
// l2c normal-loop stage top
// config registers, normal loop and ifmap/ipsum/opsum done trackers
//====================================================================
`timescale 1ns/1ps

module l2c_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start_i,
    input  logic                          cfg_we_i,
    input  logic                          cfg_addr_i,
    input  logic [31:0]                   cfg_wdata_i,
    input  logic [l2c_pkg::NUM_FIFO-1:0]  ifmap_pop_i,
    input  logic [l2c_pkg::NUM_FIFO-1:0]  ipsum_pop_i,
    input  logic [l2c_pkg::NUM_FIFO-1:0]  opsum_push_i,
    output logic [l2c_pkg::NUM_FIFO-1:0]  ifmap_need_o,
    output logic [l2c_pkg::NUM_FIFO-1:0]  ipsum_need_o,
    output logic [l2c_pkg::NUM_FIFO-1:0]  opsum_need_o,
    output logic [l2c_pkg::NUM_FIFO-1:0]  ifmap_done_o,
    output logic [l2c_pkg::NUM_FIFO-1:0]  ipsum_done_o,
    output logic [l2c_pkg::NUM_FIFO-1:0]  opsum_done_o,
    output logic                          loop_done_o
);

    layer_cfg_if cfg_if ();

    logic [l2c_pkg::CNT_W-1:0] ifmap_cnt [l2c_pkg::NUM_FIFO];   // per-fifo pops
    logic [l2c_pkg::CNT_W-1:0] ipsum_cnt [l2c_pkg::NUM_FIFO];
    logic [l2c_pkg::CNT_W-1:0] opsum_cnt [l2c_pkg::NUM_FIFO];  // per-fifo pushes

    l2c_cfg_regs regs_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg         (cfg_if.regs)
    );

    l2c_normal_loop loop_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .cfg          (cfg_if.loop),
        .ifmap_need_o (ifmap_need_o),
        .ipsum_need_o (ipsum_need_o),
        .opsum_need_o (opsum_need_o),
        .ifmap_cnt_o  (ifmap_cnt),
        .ipsum_cnt_o  (ipsum_cnt),
        .opsum_cnt_o  (opsum_cnt),
        .ifmap_done_i (ifmap_done_o),
        .ipsum_done_i (ipsum_done_o),
        .opsum_done_i (opsum_done_o),
        .loop_done_o  (loop_done_o)
    );

    //================================================================
    // done trackers, one per fifo bank
    //================================================================
    fifo_done_tracker ifmap_trk_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .need_i  (ifmap_need_o),
        .cnt_i   (ifmap_cnt),
        .event_i (ifmap_pop_i),
        .done_o  (ifmap_done_o)
    );

    fifo_done_tracker ipsum_trk_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .need_i  (ipsum_need_o),
        .cnt_i   (ipsum_cnt),
        .event_i (ipsum_pop_i),
        .done_o  (ipsum_done_o)
    );

    fifo_done_tracker opsum_trk_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .need_i  (opsum_need_o),
        .cnt_i   (opsum_cnt),
        .event_i (opsum_push_i),
        .done_o  (opsum_done_o)
    );

endmodule

//--- verilog/layer_cfg_if.sv
//====================================================================
// layer configuration link
// latched layer setup from the register block to the normal loop
//====================================================================
`timescale 1ns/1ps

interface layer_cfg_if;

    logic [1:0]         layer_type;            // LT_* code
    logic [7:0]         ic_real;               // real input channels
    logic [7:0]         oc_real;               // real output channels
    l2c_pkg::l2c_geom_u geom;                  // conv or vec view
    logic               cfg_valid;             // both words written
    logic               busy;                  // loop running holds config

    modport regs (
        output layer_type, ic_real, oc_real, geom, cfg_valid,
        input  busy
    );

    modport loop (
        input  layer_type, ic_real, oc_real, geom, cfg_valid,
        output busy
    );

endinterface
